/* Makefile */
TOP := tb_axi_many_to_one
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/axi_many_to_one.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_many_to_one import axi_mux_pkg::*; #(
    parameter int N_PORTS = 4
) (
    input  wire clk,
    input  wire resetn,

    // Upstream ports
    input  wire addr_req_t     s_aw [N_PORTS],
    input  wire [N_PORTS-1:0]  s_aw_valid,
    output logic [N_PORTS-1:0] s_aw_ready,
    input  wire w_beat_t       s_w [N_PORTS],
    input  wire [N_PORTS-1:0]  s_w_valid,
    output logic [N_PORTS-1:0] s_w_ready,
    output b_beat_t            s_b [N_PORTS],
    output logic [N_PORTS-1:0] s_b_valid,
    input  wire [N_PORTS-1:0]  s_b_ready,
    input  wire addr_req_t     s_ar [N_PORTS],
    input  wire [N_PORTS-1:0]  s_ar_valid,
    output logic [N_PORTS-1:0] s_ar_ready,
    output r_beat_t            s_r [N_PORTS],
    output logic [N_PORTS-1:0] s_r_valid,
    input  wire [N_PORTS-1:0]  s_r_ready,

    // Downstream port
    output addr_req_t    m_aw,
    output logic         m_aw_valid,
    input  wire          m_aw_ready,
    output w_beat_t      m_w,
    output logic         m_w_valid,
    input  wire          m_w_ready,
    input  wire b_beat_t m_b,
    input  wire          m_b_valid,
    output logic         m_b_ready,
    output addr_req_t    m_ar,
    output logic         m_ar_valid,
    input  wire          m_ar_ready,
    input  wire r_beat_t m_r,
    input  wire          m_r_valid,
    output logic         m_r_ready
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [N_PORTS-1:0] request;
    logic               grant_valid;
    logic [IDX_W-1:0]   grant_index;
    logic               grant_release;

    logic aw_open, w_open, ar_open, resp_open;
    logic aw_fire, ar_fire, w_last_fire, b_fire, r_last_fire;
    logic aw_pending, ar_pending;

    addr_req_t sl_aw, sl_ar;
    w_beat_t   sl_w;
    b_beat_t   sl_b;
    r_beat_t   sl_r;
    logic      sl_aw_valid, sl_aw_ready, sl_w_valid, sl_w_ready;
    logic      sl_ar_valid, sl_ar_ready;
    logic      sl_b_valid, sl_b_ready, sl_r_valid, sl_r_ready;

    assign request = s_aw_valid | s_ar_valid;

    rr_arbiter #(.N_PORTS(N_PORTS)) u_arbiter (
        .clk(clk), .resetn(resetn), .request(request), .grant_release(grant_release),
        .grant_valid(grant_valid), .grant_index(grant_index)
    );

    txn_tracker u_tracker (
        .clk(clk), .resetn(resetn), .grant_valid(grant_valid),
        .aw_pending(aw_pending), .ar_pending(ar_pending),
        .aw_fire(aw_fire), .ar_fire(ar_fire), .w_last_fire(w_last_fire),
        .b_fire(b_fire), .r_last_fire(r_last_fire),
        .aw_open(aw_open), .w_open(w_open), .ar_open(ar_open),
        .resp_open(resp_open), .grant_release(grant_release)
    );

    port_switch #(.N_PORTS(N_PORTS)) u_switch (
        .grant_index(grant_index),
        .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
        .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
        .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
        .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
        .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready),
        .sl_aw(sl_aw), .sl_aw_valid(sl_aw_valid), .sl_aw_ready(sl_aw_ready),
        .sl_w(sl_w), .sl_w_valid(sl_w_valid), .sl_w_ready(sl_w_ready),
        .sl_ar(sl_ar), .sl_ar_valid(sl_ar_valid), .sl_ar_ready(sl_ar_ready),
        .sl_b(sl_b), .sl_b_valid(sl_b_valid), .sl_b_ready(sl_b_ready),
        .sl_r(sl_r), .sl_r_valid(sl_r_valid), .sl_r_ready(sl_r_ready),
        .aw_open(aw_open), .w_open(w_open), .ar_open(ar_open), .resp_open(resp_open),
        .aw_fire(aw_fire), .ar_fire(ar_fire), .w_last_fire(w_last_fire),
        .b_fire(b_fire), .r_last_fire(r_last_fire),
        .aw_pending(aw_pending), .ar_pending(ar_pending)
    );

    // Request slices toward the downstream port
    axi_slice #(.payload_t(addr_req_t)) u_aw_slice (
        .clk(clk), .resetn(resetn),
        .in_valid(sl_aw_valid), .in_ready(sl_aw_ready), .in_data(sl_aw),
        .out_valid(m_aw_valid), .out_ready(m_aw_ready), .out_data(m_aw)
    );

    axi_slice #(.payload_t(w_beat_t)) u_w_slice (
        .clk(clk), .resetn(resetn),
        .in_valid(sl_w_valid), .in_ready(sl_w_ready), .in_data(sl_w),
        .out_valid(m_w_valid), .out_ready(m_w_ready), .out_data(m_w)
    );

    axi_slice #(.payload_t(addr_req_t)) u_ar_slice (
        .clk(clk), .resetn(resetn),
        .in_valid(sl_ar_valid), .in_ready(sl_ar_ready), .in_data(sl_ar),
        .out_valid(m_ar_valid), .out_ready(m_ar_ready), .out_data(m_ar)
    );

    // Response slices back from the downstream port
    axi_slice #(.payload_t(b_beat_t)) u_b_slice (
        .clk(clk), .resetn(resetn),
        .in_valid(m_b_valid), .in_ready(m_b_ready), .in_data(m_b),
        .out_valid(sl_b_valid), .out_ready(sl_b_ready), .out_data(sl_b)
    );

    axi_slice #(.payload_t(r_beat_t)) u_r_slice (
        .clk(clk), .resetn(resetn),
        .in_valid(m_r_valid), .in_ready(m_r_ready), .in_data(m_r),
        .out_valid(sl_r_valid), .out_ready(sl_r_ready), .out_data(sl_r)
    );

endmodule

`default_nettype wire

/* hdl/axi_mux_pkg.sv */
`default_nettype none

package axi_mux_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W = 4;

    // Wide enough to hold MAX_OUTSTANDING itself
    localparam int CNT_W = 3;
    localparam int MAX_OUTSTANDING = 4;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } addr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TRANSACTION,
        ST_FINISH
    } tracker_state_t;

endpackage

`default_nettype wire

/* hdl/axi_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_slice #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           resetn,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);

    logic     full;
    payload_t data_q;

    // Free, or emptying this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data = data_q;

endmodule

`default_nettype wire

/* hdl/port_switch.sv */
`timescale 1ns/1ns
`default_nettype none

module port_switch import axi_mux_pkg::*; #(
    parameter int N_PORTS = 4
) (
    input  wire  [((N_PORTS > 1) ? $clog2(N_PORTS) : 1)-1:0] grant_index,

    input  wire addr_req_t    s_aw [N_PORTS],
    input  wire [N_PORTS-1:0] s_aw_valid,
    output logic [N_PORTS-1:0] s_aw_ready,
    input  wire w_beat_t      s_w [N_PORTS],
    input  wire [N_PORTS-1:0] s_w_valid,
    output logic [N_PORTS-1:0] s_w_ready,
    input  wire addr_req_t    s_ar [N_PORTS],
    input  wire [N_PORTS-1:0] s_ar_valid,
    output logic [N_PORTS-1:0] s_ar_ready,
    output b_beat_t           s_b [N_PORTS],
    output logic [N_PORTS-1:0] s_b_valid,
    input  wire [N_PORTS-1:0] s_b_ready,
    output r_beat_t           s_r [N_PORTS],
    output logic [N_PORTS-1:0] s_r_valid,
    input  wire [N_PORTS-1:0] s_r_ready,

    // Request slice inputs
    output addr_req_t sl_aw,
    output logic      sl_aw_valid,
    input  wire       sl_aw_ready,
    output w_beat_t   sl_w,
    output logic      sl_w_valid,
    input  wire       sl_w_ready,
    output addr_req_t sl_ar,
    output logic      sl_ar_valid,
    input  wire       sl_ar_ready,

    // Response slice outputs
    input  wire b_beat_t sl_b,
    input  wire          sl_b_valid,
    output logic         sl_b_ready,
    input  wire r_beat_t sl_r,
    input  wire          sl_r_valid,
    output logic         sl_r_ready,

    input  wire  aw_open,
    input  wire  w_open,
    input  wire  ar_open,
    input  wire  resp_open,
    output logic aw_fire,
    output logic ar_fire,
    output logic w_last_fire,
    output logic b_fire,
    output logic r_last_fire,
    output logic aw_pending,
    output logic ar_pending
);

    assign aw_pending = s_aw_valid[grant_index];
    assign ar_pending = s_ar_valid[grant_index];

    assign sl_aw = s_aw[grant_index];
    assign sl_w = s_w[grant_index];
    assign sl_ar = s_ar[grant_index];

    assign sl_aw_valid = s_aw_valid[grant_index] && aw_open;
    assign sl_w_valid = s_w_valid[grant_index] && w_open;
    assign sl_ar_valid = s_ar_valid[grant_index] && ar_open;
    assign sl_b_ready = s_b_ready[grant_index] && resp_open;
    assign sl_r_ready = s_r_ready[grant_index] && resp_open;

    // Only the granted port sees ready or a response valid
    always_comb begin
        s_aw_ready = '0;
        s_w_ready = '0;
        s_ar_ready = '0;
        s_b_valid = '0;
        s_r_valid = '0;
        s_aw_ready[grant_index] = sl_aw_ready && aw_open;
        s_w_ready[grant_index] = sl_w_ready && w_open;
        s_ar_ready[grant_index] = sl_ar_ready && ar_open;
        s_b_valid[grant_index] = sl_b_valid && resp_open;
        s_r_valid[grant_index] = sl_r_valid && resp_open;
        for (int i = 0; i < N_PORTS; i++) begin
            s_b[i] = sl_b;
            s_r[i] = sl_r;
        end
    end

    assign aw_fire = sl_aw_valid && sl_aw_ready;
    assign ar_fire = sl_ar_valid && sl_ar_ready;
    assign w_last_fire = sl_w_valid && sl_w_ready && sl_w.last;
    assign b_fire = sl_b_valid && sl_b_ready;
    assign r_last_fire = sl_r_valid && sl_r_ready && sl_r.last;

endmodule

`default_nettype wire

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter #(
    parameter int N_PORTS = 4
) (
    input  wire                                           clk,
    input  wire                                           resetn,
    input  wire  [N_PORTS-1:0]                            request,
    input  wire                                           grant_release,
    output logic                                          grant_valid,
    output logic [((N_PORTS > 1) ? $clog2(N_PORTS) : 1)-1:0] grant_index
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] next_ptr;
    logic [IDX_W-1:0] cand;
    logic [IDX_W-1:0] pick;
    logic             found;

    // First requester at or after ptr, wrapping
    always_comb begin
        found = 1'b0;
        pick = ptr;
        cand = ptr;
        for (int i = 0; i < N_PORTS; i++) begin
            cand = IDX_W'((int'(ptr) + i) % N_PORTS);
            if (!found && request[cand]) begin
                found = 1'b1;
                pick = cand;
            end
        end
    end

    assign next_ptr = (grant_index == IDX_W'(N_PORTS - 1)) ? '0 : grant_index + 1'b1;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            grant_valid <= 1'b0;
            grant_index <= '0;
            ptr <= '0;
        end else if (grant_valid) begin
            // Held until the tracker lets go
            if (grant_release) begin
                grant_valid <= 1'b0;
                ptr <= next_ptr;
            end
        end else if (found) begin
            grant_valid <= 1'b1;
            grant_index <= pick;
        end
    end

endmodule

`default_nettype wire

/* hdl/txn_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module txn_tracker import axi_mux_pkg::*; (
    input  wire  clk,
    input  wire  resetn,
    input  wire  grant_valid,
    input  wire  aw_pending,
    input  wire  ar_pending,
    input  wire  aw_fire,
    input  wire  ar_fire,
    input  wire  w_last_fire,
    input  wire  b_fire,
    input  wire  r_last_fire,
    output logic aw_open,
    output logic w_open,
    output logic ar_open,
    output logic resp_open,
    output logic grant_release
);

    tracker_state_t state;
    tracker_state_t state_next;

    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] rd_cnt;
    // Bursts announced on AW whose last W beat is still to come
    logic [CNT_W-1:0] wlast_cnt;

    logic counts_zero;
    logic finish_cond;

    function automatic logic [CNT_W-1:0] step(
        input logic [CNT_W-1:0] cnt,
        input logic             up,
        input logic             down
    );
        logic [CNT_W-1:0] res;
        res = cnt;
        if (up && !down) begin
            res = cnt + 1'b1;
        end else if (down && !up) begin
            res = cnt - 1'b1;
        end
        return res;
    endfunction

    assign counts_zero = (wr_cnt == '0) && (rd_cnt == '0) && (wlast_cnt == '0);
    assign finish_cond = !aw_pending && !ar_pending && counts_zero;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (grant_valid) begin
                    state_next = ST_TRANSACTION;
                end
            end
            ST_TRANSACTION: begin
                if (finish_cond) begin
                    state_next = ST_FINISH;
                end
            end
            ST_FINISH: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= ST_IDLE;
            wr_cnt <= '0;
            rd_cnt <= '0;
            wlast_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == ST_FINISH) begin
                wr_cnt <= '0;
                rd_cnt <= '0;
                wlast_cnt <= '0;
            end else begin
                wr_cnt <= step(wr_cnt, aw_fire, b_fire);
                rd_cnt <= step(rd_cnt, ar_fire, r_last_fire);
                wlast_cnt <= step(wlast_cnt, aw_fire, w_last_fire);
            end
        end
    end

    // Address channels close once the per-direction limit is reached
    assign aw_open = (state == ST_TRANSACTION) && aw_pending
                     && (wr_cnt < CNT_W'(MAX_OUTSTANDING));
    assign ar_open = (state == ST_TRANSACTION) && ar_pending
                     && (rd_cnt < CNT_W'(MAX_OUTSTANDING));
    assign w_open = (wlast_cnt != '0);
    assign resp_open = (state == ST_TRANSACTION);
    assign grant_release = (state == ST_FINISH);

endmodule

`default_nettype wire

/* tb.f */
hdl/axi_mux_pkg.sv
hdl/rr_arbiter.sv
hdl/txn_tracker.sv
hdl/axi_slice.sv
hdl/port_switch.sv
hdl/axi_many_to_one.sv
testbench/axi_mem_model.sv
testbench/tb_axi_many_to_one.sv

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model import axi_mux_pkg::*; #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] FILL_KEY = 32'h5a3c_0000
) (
    input  wire            clk,
    input  wire            hold_b,
    input  wire            rand_stall,
    input  wire addr_req_t m_aw,
    input  wire            m_aw_valid,
    output logic           m_aw_ready,
    input  wire w_beat_t   m_w,
    input  wire            m_w_valid,
    output logic           m_w_ready,
    output b_beat_t        m_b,
    output logic           m_b_valid,
    input  wire            m_b_ready,
    input  wire addr_req_t m_ar,
    input  wire            m_ar_valid,
    output logic           m_ar_ready,
    output r_beat_t        m_r,
    output logic           m_r_valid,
    input  wire            m_r_ready
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    addr_req_t         aw_q[$];
    addr_req_t         ar_q[$];
    b_beat_t           b_q[$];
    int                w_beat;
    int                r_beat;
    int                idx;
    logic              b_fired;
    logic              r_fired;

    function automatic int word_index(input addr_req_t req, input int beat);
        return (int'(req.addr >> 2) + beat) % MEM_WORDS;
    endfunction

    // Random stall roughly one cycle in four
    function automatic logic go();
        return !rand_stall || ($urandom % 4 != 0);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = FILL_KEY ^ (i * 32'h0001_0003);
        end
        m_aw_ready = 1'b0;
        m_w_ready = 1'b0;
        m_ar_ready = 1'b0;
        m_b_valid = 1'b0;
        m_b = '0;
        m_r_valid = 1'b0;
        m_r = '0;
        w_beat = 0;
        r_beat = 0;
    end

    // Sample handshakes on the rising edge, drive on the falling edge
    initial forever begin
        @(posedge clk);
        b_fired = m_b_valid && m_b_ready;
        r_fired = m_r_valid && m_r_ready;
        if (m_aw_valid && m_aw_ready) begin
            aw_q.push_back(m_aw);
        end
        if (m_w_valid && m_w_ready) begin
            idx = word_index(aw_q[0], w_beat);
            for (int b = 0; b < STRB_W; b++) begin
                if (m_w.strb[b]) begin
                    mem[idx][8*b +: 8] = m_w.data[8*b +: 8];
                end
            end
            if (m_w.last) begin
                b_q.push_back('{id: aw_q[0].id, resp: RESP_OKAY});
                void'(aw_q.pop_front());
                w_beat = 0;
            end else begin
                w_beat++;
            end
        end
        if (b_fired) begin
            void'(b_q.pop_front());
        end
        if (m_ar_valid && m_ar_ready) begin
            ar_q.push_back(m_ar);
        end
        if (r_fired) begin
            if (m_r.last) begin
                void'(ar_q.pop_front());
                r_beat = 0;
            end else begin
                r_beat++;
            end
        end

        @(negedge clk);
        m_aw_ready = go();
        m_w_ready = (aw_q.size() > 0) && go();
        m_ar_ready = go();
        // A raised valid stays until it transfers
        if (!(m_b_valid && !b_fired)) begin
            m_b_valid = (b_q.size() > 0) && !hold_b && go();
            if (m_b_valid) begin
                m_b = b_q[0];
            end
        end
        if (!(m_r_valid && !r_fired)) begin
            m_r_valid = (ar_q.size() > 0) && go();
            if (m_r_valid) begin
                m_r = '{id: ar_q[0].id, data: mem[word_index(ar_q[0], r_beat)],
                        resp: RESP_OKAY, last: (r_beat == int'(ar_q[0].len))};
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_axi_many_to_one.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_many_to_one import axi_mux_pkg::*; ();

    localparam int          N_PORTS = 4;
    localparam logic [31:0] SEED = 32'h567c_1055;
    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] FILL_KEY = 32'h5a3c_0000;
    localparam int          WAIT_LIMIT = 2000;
    localparam int          RAND_ITERS = 6;

    logic clk;
    logic resetn;
    logic hold_b;
    logic rand_stall;

    addr_req_t          s_aw [N_PORTS];
    logic [N_PORTS-1:0] s_aw_valid, s_aw_ready;
    w_beat_t            s_w [N_PORTS];
    logic [N_PORTS-1:0] s_w_valid, s_w_ready;
    b_beat_t            s_b [N_PORTS];
    logic [N_PORTS-1:0] s_b_valid, s_b_ready;
    addr_req_t          s_ar [N_PORTS];
    logic [N_PORTS-1:0] s_ar_valid, s_ar_ready;
    r_beat_t            s_r [N_PORTS];
    logic [N_PORTS-1:0] s_r_valid, s_r_ready;

    addr_req_t m_aw, m_ar;
    w_beat_t   m_w;
    b_beat_t   m_b;
    r_beat_t   m_r;
    logic      m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    logic      m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [ID_W-1:0]   aw_ids[$];
    int aw_down, b_down, b_up;
    int n_checks, n_errors, n_timeouts;

    axi_many_to_one #(.N_PORTS(N_PORTS)) UUT (
        .clk(clk), .resetn(resetn),
        .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
        .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
        .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
        .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
        .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready),
        .m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
        .m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
        .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
        .m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
        .m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
    );

    axi_mem_model #(.MEM_WORDS(MEM_WORDS), .FILL_KEY(FILL_KEY)) u_mem (
        .clk(clk), .hold_b(hold_b), .rand_stall(rand_stall),
        .m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
        .m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
        .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
        .m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
        .m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        n_checks++;
        assert (expected === actual) else begin
            n_errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    function automatic logic pick_ready();
        return !rand_stall || ($urandom % 3 != 0);
    endfunction

    // Word-aligned burst that stays inside the port's 64-word window
    function automatic logic [31:0] random_addr(input int p, input int len);
        return 32'(p * 256 + int'($urandom % (64 - len)) * 4);
    endfunction

    // Handshake monitor with routing and outstanding-limit checks
    always @(posedge clk) begin
        if (resetn) begin
            if (m_aw_valid && m_aw_ready) begin
                aw_ids.push_back(m_aw.id);
                aw_down++;
            end
            if (m_b_valid && m_b_ready) b_down++;
            for (int p = 0; p < N_PORTS; p++) begin
                if (s_b_valid[p] && s_b_ready[p]) b_up++;
                if (s_b_valid[p]) check_value("b_route", 64'(p), 64'(s_b[p].id));
                if (s_r_valid[p]) check_value("r_route", 64'(p), 64'(s_r[p].id));
            end
            check_true(aw_down - b_down <= MAX_OUTSTANDING, "too many writes outstanding");
        end
    end

    task automatic send_aw(input int p, input logic [31:0] addr, input int len);
        int t;
        logic fired;
        t = 0;
        fired = 1'b0;
        @(negedge clk);
        s_aw[p] = '{id: ID_W'(p), addr: addr, len: 8'(len), size: 3'd2, burst: 2'b01};
        s_aw_valid[p] = 1'b1;
        while (!fired && t < WAIT_LIMIT) begin
            @(posedge clk);
            fired = s_aw_ready[p];
            t++;
        end
        if (!fired) report_timeout("AW ready");
        @(negedge clk);
        s_aw_valid[p] = 1'b0;
    endtask

    task automatic send_w(input int p, input logic [31:0] addr, input int len);
        int t;
        int idx;
        logic fired;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        for (int beat = 0; beat <= len; beat++) begin
            data = $urandom;
            strb = STRB_W'($urandom);
            idx = (int'(addr >> 2) + beat) % MEM_WORDS;
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
            if (beat > 0) @(negedge clk);
            s_w[p] = '{data: data, strb: strb, last: (beat == len)};
            s_w_valid[p] = 1'b1;
            t = 0;
            fired = 1'b0;
            while (!fired && t < WAIT_LIMIT) begin
                @(posedge clk);
                fired = s_w_ready[p];
                t++;
            end
            if (!fired) report_timeout("W ready");
        end
        @(negedge clk);
        s_w_valid[p] = 1'b0;
    endtask

    task automatic wait_b(input int p);
        int t;
        logic got;
        t = 0;
        got = 1'b0;
        while (!got && t < WAIT_LIMIT) begin
            @(negedge clk);
            s_b_ready[p] = pick_ready();
            @(posedge clk);
            got = s_b_valid[p] && s_b_ready[p];
            t++;
        end
        if (!got) begin
            report_timeout("write response");
        end else begin
            check_value("bid", 64'(p), 64'(s_b[p].id));
            check_value("bresp", 64'(RESP_OKAY), 64'(s_b[p].resp));
        end
    endtask

    task automatic write_txn(input int p, input logic [31:0] addr, input int len);
        send_aw(p, addr, len);
        send_w(p, addr, len);
        wait_b(p);
    endtask

    task automatic read_burst(input int p, input logic [31:0] addr, input int len);
        int t;
        int beat;
        logic fired;
        t = 0;
        fired = 1'b0;
        @(negedge clk);
        s_ar[p] = '{id: ID_W'(p), addr: addr, len: 8'(len), size: 3'd2, burst: 2'b01};
        s_ar_valid[p] = 1'b1;
        while (!fired && t < WAIT_LIMIT) begin
            @(posedge clk);
            fired = s_ar_ready[p];
            t++;
        end
        if (!fired) report_timeout("AR ready");
        @(negedge clk);
        s_ar_valid[p] = 1'b0;
        beat = 0;
        t = 0;
        while (beat <= len && t < WAIT_LIMIT) begin
            s_r_ready[p] = pick_ready();
            @(posedge clk);
            if (s_r_valid[p] && s_r_ready[p]) begin
                check_value("rdata", 64'(ref_mem[(int'(addr >> 2) + beat) % MEM_WORDS]),
                            64'(s_r[p].data));
                check_value("rid", 64'(p), 64'(s_r[p].id));
                check_value("rresp", 64'(RESP_OKAY), 64'(s_r[p].resp));
                check_value("rlast", 64'(beat == len), 64'(s_r[p].last));
                beat++;
            end
            t++;
            @(negedge clk);
        end
        if (beat <= len) report_timeout("read data");
        s_r_ready[p] = 1'b0;
    endtask

    task automatic port_traffic(input int p);
        int len;
        logic [31:0] addr;
        for (int i = 0; i < RAND_ITERS; i++) begin
            len = int'($urandom % 8);
            addr = random_addr(p, len);
            write_txn(p, addr, len);
            read_burst(p, addr, len);
            len = int'($urandom % 8);
            read_burst(p, random_addr(p, len), len);
        end
    endtask

    initial begin
        int t;
        int aw_start;
        int b_start;
        void'($urandom(SEED));
        resetn = 1'b0;
        hold_b = 1'b0;
        rand_stall = 1'b0;
        s_aw_valid = '0;
        s_w_valid = '0;
        s_ar_valid = '0;
        s_b_ready = '0;
        s_r_ready = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            s_aw[p] = '0;
            s_w[p] = '0;
            s_ar[p] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = FILL_KEY ^ (i * 32'h0001_0003);
        end
        aw_down = 0;
        b_down = 0;
        b_up = 0;
        n_checks = 0;
        n_errors = 0;
        n_timeouts = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // Idle after reset
        repeat (10) begin
            @(posedge clk);
            check_value("idle_ready", 0, 64'({s_aw_ready, s_w_ready, s_ar_ready}));
            check_value("idle_valid", 0,
                        64'({m_aw_valid, m_w_valid, m_ar_valid, s_b_valid, s_r_valid}));
        end

        // All ports at once in round-robin order from port 0
        aw_ids.delete();
        fork
            write_txn(0, random_addr(0, 1), 1);
            write_txn(1, random_addr(1, 2), 2);
            write_txn(2, random_addr(2, 0), 0);
            write_txn(3, random_addr(3, 3), 3);
        join
        check_value("aw_order_count", 4, 64'(aw_ids.size()));
        for (int i = 0; i < aw_ids.size() && i < 4; i++) begin
            check_value("aw_order", 64'(i), 64'(aw_ids[i]));
        end

        // Single burst write and read back on port 0
        write_txn(0, 32'h0000_0040, 3);
        read_burst(0, 32'h0000_0040, 3);

        // Outstanding limit while B is withheld
        hold_b = 1'b1;
        aw_start = aw_down;
        b_start = b_up;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_aw(0, 32'(i * 16), 3);
                    send_w(0, 32'(i * 16), 3);
                end
            end
            begin
                for (int i = 0; i < 6; i++) begin
                    wait_b(0);
                end
            end
            begin
                t = 0;
                while (aw_down - aw_start < MAX_OUTSTANDING && t < WAIT_LIMIT) begin
                    @(posedge clk);
                    t++;
                end
                if (aw_down - aw_start < MAX_OUTSTANDING) report_timeout("held AW bursts");
                repeat (30) @(posedge clk);
                @(negedge clk);
                check_value("aw_before_b", 64'(MAX_OUTSTANDING), 64'(aw_down - aw_start));
                check_value("b_before_release", 0, 64'(b_up - b_start));
                hold_b = 1'b0;
            end
        join

        // Random mixed traffic on every port
        rand_stall = 1'b1;
        fork
            port_traffic(0);
            port_traffic(1);
            port_traffic(2);
            port_traffic(3);
        join
        repeat (5) @(posedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
